/* dv/fifo_pipe_asserts.sv */
//****************************************
// fifo pipe handshake checks bound into
// the top level
//****************************************

`timescale 1ns/100ps

module fifo_pipe_asserts
   import fifo_geom_pkg::*;
   import stage_ctrl_pkg::*;
(
   input logic  clk_i,
   input logic  rst_n_i,
   input logic  in_valid_i,
   input logic  in_ready_i,
   input logic  out_valid_i,
   input logic  out_ready_i,
   input data_t out_data_i,
   input logic  deq_valid_i,
   input logic  deq_yumi_i
);

   // memory entries plus the output register
   localparam int HELD_MAX = DEPTH + 1;

   out_state_e out_view;
   logic       in_fire;
   logic       out_fire;
   int         held_q;
   int         buf_words;

   // output register state as seen from the ports
   assign out_view = out_valid_i ? OUT_HELD : OUT_EMPTY;
   assign in_fire  = in_valid_i & in_ready_i;
   assign out_fire = out_valid_i & out_ready_i;

   // words inside the pipe counted at the two top-level handshakes
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         held_q <= 0;
      else
         held_q <= held_q + int'(in_fire) - int'(out_fire);
   end

   // words waiting in the buffer behind the output register
   assign buf_words = held_q - int'(out_valid_i);

   // a stalled word keeps valid and data until it is taken
   stall_hold_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (out_view == OUT_HELD && !out_ready_i) |=> (out_valid_i && $stable(out_data_i)))
      else $error("output word changed or vanished while stalled");

   // full pipe must refuse input
   full_ready_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (held_q == HELD_MAX) |-> !in_ready_i)
      else $error("input ready while the pipe holds all words");

   // yumi only takes a word that the buffer really holds
   yumi_valid_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      deq_yumi_i |-> (deq_valid_i && buf_words > 0))
      else $error("yumi raised without a word waiting in the buffer");

endmodule

bind fifo_pipe_top fifo_pipe_asserts asserts_inst
(
   .clk_i       (clk_i),
   .rst_n_i     (rst_n_i),
   .in_valid_i  (in_valid_i),
   .in_ready_i  (in_ready_o),
   .out_valid_i (out_valid_o),
   .out_ready_i (out_ready_i),
   .out_data_i  (out_data_o),
   .deq_valid_i (deq_valid),
   .deq_yumi_i  (deq_yumi)
);

/* dv/fifo_pipe_tb.sv */
//****************************************
// fifo pipe testbench driving reset,
// latency, streaming, back-pressure and
// random traffic
//****************************************

`timescale 1ns/100ps

module fifo_pipe_tb
   import fifo_geom_pkg::*;
();

   localparam int          CLK_PERIOD   = 4;
   localparam int          RESET_CYCLES = 5;
   localparam int unsigned SEED         = 32'h64fa_2c82;
   localparam int          CAPACITY     = DEPTH + 1;
   localparam int          STREAM_WORDS = 16;
   localparam int          RANDOM_WORDS = 2000;
   localparam int          TOTAL_WORDS  = 1 + STREAM_WORDS + CAPACITY + RANDOM_WORDS;
   // 20 cycles per word leaves room for random stalls
   localparam int          WATCHDOG_CYCLES = RESET_CYCLES + 20 * TOTAL_WORDS;

   logic  clk_i;
   logic  rst_n_i;
   logic  in_valid_i;
   data_t in_data_i;
   logic  out_ready_i;
   logic  in_ready_o;
   logic  out_valid_o;
   data_t out_data_o;

   // monitor state updated on the falling edge
   int    in_count     = 0;
   int    out_count    = 0;
   int    cyc          = 0;
   int    last_in_cyc  = 0;
   int    last_out_cyc = 0;
   logic  ready_smp    = 1'b0;
   logic  stalled_q    = 1'b0;
   data_t held_q       = '0;
   // window where the output must not skip a cycle
   logic  gap_on       = 1'b0;
   int    gap_lo       = 0;
   int    gap_hi       = 0;

   fifo_pipe_top fifo_pipe_top_inst
   (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .in_valid_i  (in_valid_i),
      .in_data_i   (in_data_i),
      .out_ready_i (out_ready_i),
      .in_ready_o  (in_ready_o),
      .out_valid_o (out_valid_o),
      .out_data_o  (out_data_o)
   );

   // expected word k of the stream as a fixed hash of k and the seed
   function automatic data_t word_for_index(input int unsigned k);
      logic [31:0] h;
      h = k * 32'h9e37_79b9;
      h = h ^ SEED;
      h = h ^ (h >> 15);
      h = h * 32'h2c1b_3c6d;
      return data_t'(h ^ (h >> 16));
   endfunction

   task automatic abort_run(input string msg);
      $display("%s at %0t ns", msg, $time);
      $display("*** FAILED ***");
      $fatal(1, "run stopped on first error");
   endtask

   task automatic report_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run("value mismatch");
   endtask

   initial
   begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   // watchdog sized from the total word count
   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      abort_run("watchdog expired before all words came out");
   end

   // comparing process sampling on the falling edge
   always @(negedge clk_i)
   begin
      cyc = cyc + 1;
      ready_smp = in_ready_o;
      if (rst_n_i)
      begin
         if (gap_on && out_count > gap_lo && out_count < gap_hi)
            assert (out_valid_o) else abort_run("gap in back-to-back output stream");
         if (stalled_q)
            assert (out_data_o == held_q)
               else report_value("out_data_o", 32'(out_data_o), 32'(held_q));
         // output side first since a word cannot leave in its own accept cycle
         if (out_valid_o && out_ready_i)
         begin
            assert (out_count < in_count) else abort_run("output word never sent in");
            assert (out_data_o == word_for_index(out_count))
               else report_value("out_data_o", 32'(out_data_o),
                                 32'(word_for_index(out_count)));
            out_count = out_count + 1;
            last_out_cyc = cyc;
         end
         if (in_valid_i && in_ready_o)
         begin
            in_count = in_count + 1;
            last_in_cyc = cyc;
         end
         stalled_q = out_valid_o && !out_ready_i;
         held_q = out_data_o;
      end
   end

   task automatic check_idle();
      assert (!out_valid_o) else report_value("out_valid_o", 32'(out_valid_o), 32'h0);
      assert (in_ready_o) else report_value("in_ready_o", 32'(in_ready_o), 32'h1);
   endtask

   task automatic check_reset();
      int k;
      for (k = 0; k < RESET_CYCLES; k++)
      begin
         @(negedge clk_i);
         check_idle();
      end
      @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(negedge clk_i);
      check_idle();
   endtask

   // random valid and ready until n more words have left the pipe
   task automatic run_traffic(input int n, input int valid_pct, input int ready_pct);
      int target;
      target = in_count + n;
      while (out_count < target)
      begin
         @(posedge clk_i);
         in_valid_i  <= (in_count < target) && ($urandom_range(99) < valid_pct);
         in_data_i   <= word_for_index(in_count);
         out_ready_i <= ($urandom_range(99) < ready_pct);
      end
   endtask

   task automatic fill_and_release();
      int base;
      int k;
      base = in_count;
      // output blocked while a word is offered every cycle
      for (k = 0; k < 4 * CAPACITY; k++)
      begin
         @(posedge clk_i);
         in_valid_i  <= 1'b1;
         in_data_i   <= word_for_index(in_count);
         out_ready_i <= 1'b0;
      end
      @(posedge clk_i);
      assert (in_count - base == CAPACITY)
         else report_value("accepted words", 32'(in_count - base), 32'(CAPACITY));
      assert (!ready_smp) else report_value("in_ready_o", 32'(ready_smp), 32'h0);
      in_valid_i  <= 1'b0;
      out_ready_i <= 1'b1;
      while (out_count < base + CAPACITY)
         @(posedge clk_i);
      assert (ready_smp) else report_value("in_ready_o", 32'(ready_smp), 32'h1);
   endtask

   initial
   begin
      void'($urandom(SEED));
      rst_n_i     <= 1'b0;
      in_valid_i  <= 1'b0;
      in_data_i   <= '0;
      out_ready_i <= 1'b0;
      check_reset();
      // single word through the bypass path
      run_traffic(1, 100, 100);
      assert (last_out_cyc - last_in_cyc == 2)
         else report_value("out_valid_o latency", 32'(last_out_cyc - last_in_cyc), 32'd2);
      gap_lo = in_count;
      gap_hi = in_count + STREAM_WORDS;
      gap_on = 1'b1;
      run_traffic(STREAM_WORDS, 100, 100);
      gap_on = 1'b0;
      fill_and_release();
      // mixed bypass and memory reads with pointer wrap
      run_traffic(RANDOM_WORDS, 70, 60);
      // last word has just left so the pipe must be empty
      @(negedge clk_i);
      check_idle();
      $display("*** PASSED ***");
      $finish;
   end

endmodule

/* fifo_pipe.f */
src/fifo_geom_pkg.sv
src/stage_ctrl_pkg.sv
src/fifo_mem_if.sv
src/fifo_tracker.sv
src/mem_1r1w_sync.sv
src/fifo_1r1w_small.sv
src/out_reg_stage.sv
src/fifo_pipe_top.sv
dv/fifo_pipe_asserts.sv
dv/fifo_pipe_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fifo_pipe testbench with verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --assert --timing -j 0 \
   --top-module fifo_pipe_tb -Mdir obj_dir -f fifo_pipe.f

# the run ends through \$fatal on an error, its status is judged from the log
./obj_dir/Vfifo_pipe_tb > "${LOG}" 2>&1 || true
cat "${LOG}"

if grep -qF '*** FAILED ***' "${LOG}"; then
   echo "simulation reported failure"
   exit 1
fi

# a run stopped by an assertion never reaches the end of the testbench
if ! grep -qF '*** PASSED ***' "${LOG}"; then
   echo "simulation did not complete"
   exit 1
fi

echo "simulation completed"

/* src/fifo_1r1w_small.sv */
//**************************************
// small 1r1w buffer on sync-read memory,
// bypass register for 1-cycle latency
//**************************************

`timescale 1ns/100ps

module fifo_1r1w_small
   import fifo_geom_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_n_i,
   input  logic      in_valid_i,
   input  data_t     in_data_i,
   input  logic      deq_yumi_i,
   output logic      in_ready_o,
   output logic      deq_valid_o,
   output data_t     deq_data_o,
   fifo_mem_if.ctrl  mem
);

   logic  enq;
   logic  full;
   logic  empty;
   ptr_t  wptr;
   ptr_t  rptr_next;

   // next read address equals write address
   logic  same_addr;
   logic  bypass_load;
   logic  bypass_sel_q;
   data_t bypass_q;

   // valid and ready together
   assign enq = in_valid_i & ~full;

   // current head address is not needed, the read is prefetched
   fifo_tracker tracker_inst
   (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .enq_i       (enq),
      .deq_i       (deq_yumi_i),
      .wptr_o      (wptr),
      .rptr_o      (),
      .rptr_next_o (rptr_next),
      .full_o      (full),
      .empty_o     (empty)
   );

   // when empty and idle, rptr_next == wptr holds, so no read is issued
   assign same_addr = (rptr_next == wptr);

   // every accepted word goes to memory
   assign mem.w_v    = enq;
   assign mem.w_addr = wptr;
   assign mem.w_data = in_data_i;

   // prefetch next head, skipped on an address collision
   assign mem.r_v    = ~same_addr;
   assign mem.r_addr = rptr_next;

   // on collision a copy also lands in the bypass register
   assign bypass_load = enq & same_addr;

   always_ff @(posedge clk_i)
   begin
      if (bypass_load)
         bypass_q <= in_data_i;
   end

   // select bypass data for exactly the cycle after a collision
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         bypass_sel_q <= 1'b0;
      else
         bypass_sel_q <= bypass_load;
   end

   assign deq_data_o  = bypass_sel_q ? bypass_q : mem.r_data;
   assign deq_valid_o = ~empty;
   assign in_ready_o  = ~full;

endmodule

/* src/fifo_geom_pkg.sv */
//**************************************
// fifo geometry: word width, buffer depth
// and the vector types derived from them
//**************************************

package fifo_geom_pkg;

   // width of one stream word
   localparam int DATA_W = 16;

   // number of entries in the sync-read memory
   localparam int DEPTH = 4;

   // memory address width, at least one bit
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   // stream word
   typedef logic [DATA_W-1:0] data_t;

   // memory address
   typedef logic [PTR_W-1:0] ptr_t;

   // highest valid address, pointers wrap after it
   localparam ptr_t PTR_LAST = ptr_t'(DEPTH - 1);

endpackage

/* src/fifo_mem_if.sv */
//**************************************
// write and read ports of the sync-read
// buffer memory
//**************************************

`timescale 1ns/100ps

interface fifo_mem_if
   import fifo_geom_pkg::*;
();

   // write port
   logic  w_v;
   ptr_t  w_addr;
   data_t w_data;

   // read port, data shows one cycle after r_v
   logic  r_v;
   ptr_t  r_addr;
   data_t r_data;

   // buffer control side drives addresses and enables
   modport ctrl (output w_v, w_addr, w_data, r_v, r_addr, input r_data);

   // memory side returns read data only
   modport mem (input w_v, w_addr, w_data, r_v, r_addr, output r_data);

endinterface

/* src/fifo_pipe_top.sv */
//**************************************
// fifo pipe: buffer plus output register
//**************************************

`timescale 1ns/100ps

module fifo_pipe_top
   import fifo_geom_pkg::*;
(
   input  logic  clk_i,
   input  logic  rst_n_i,
   input  logic  in_valid_i,
   input  data_t in_data_i,
   input  logic  out_ready_i,
   output logic  in_ready_o,
   output logic  out_valid_o,
   output data_t out_data_o
);

   // buffer to output stage, valid/yumi
   logic  deq_valid;
   logic  deq_yumi;
   data_t deq_data;

   fifo_mem_if mem_if ();

   fifo_1r1w_small fifo_inst
   (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .in_valid_i  (in_valid_i),
      .in_data_i   (in_data_i),
      .deq_yumi_i  (deq_yumi),
      .in_ready_o  (in_ready_o),
      .deq_valid_o (deq_valid),
      .deq_data_o  (deq_data),
      .mem         (mem_if.ctrl)
   );

   mem_1r1w_sync mem_inst
   (
      .clk_i (clk_i),
      .mem   (mem_if.mem)
   );

   out_reg_stage out_inst
   (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .deq_valid_i (deq_valid),
      .deq_data_i  (deq_data),
      .out_ready_i (out_ready_i),
      .deq_yumi_o  (deq_yumi),
      .out_valid_o (out_valid_o),
      .out_data_o  (out_data_o)
   );

endmodule

/* src/fifo_tracker.sv */
//**************************************
// fifo tracker: read/write pointers with
// wrap bits, full and empty flags
//**************************************

`timescale 1ns/100ps

module fifo_tracker
   import fifo_geom_pkg::*;
(
   input  logic clk_i,
   input  logic rst_n_i,
   input  logic enq_i,
   input  logic deq_i,
   output ptr_t wptr_o,
   output ptr_t rptr_o,
   output ptr_t rptr_next_o,
   output logic full_o,
   output logic empty_o
);

   // msb is the wrap bit, the rest is the address
   logic [PTR_W:0] wptr_q;
   logic [PTR_W:0] rptr_q;
   logic [PTR_W:0] rptr_next;

   // advance a pointer by one entry, toggle wrap at the last address
   function automatic logic [PTR_W:0] step_ptr(input logic [PTR_W:0] p);
      logic [PTR_W:0] r;
      if (p[PTR_W-1:0] == PTR_LAST)
         r = {~p[PTR_W], {PTR_W{1'b0}}};
      else
         r = {p[PTR_W], ptr_t'(p[PTR_W-1:0] + 1'b1)};
      return r;
   endfunction

   // read pointer one cycle early, feeds the sync-read address
   assign rptr_next = deq_i ? step_ptr(rptr_q) : rptr_q;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wptr_q <= '0;
         rptr_q <= '0;
      end
      else
      begin
         if (enq_i)
            wptr_q <= step_ptr(wptr_q);
         rptr_q <= rptr_next;
      end
   end

   assign wptr_o      = wptr_q[PTR_W-1:0];
   assign rptr_o      = rptr_q[PTR_W-1:0];
   assign rptr_next_o = rptr_next[PTR_W-1:0];

   // same address: wrap bits tell full from empty
   assign empty_o = (wptr_q == rptr_q);
   assign full_o  = (wptr_q[PTR_W-1:0] == rptr_q[PTR_W-1:0])
                    && (wptr_q[PTR_W] != rptr_q[PTR_W]);

endmodule

/* src/mem_1r1w_sync.sv */
//**************************************
// one-write one-read memory with
// registered read data
//**************************************

`timescale 1ns/100ps

module mem_1r1w_sync
   import fifo_geom_pkg::*;
(
   input  logic     clk_i,
   fifo_mem_if.mem  mem
);

   // storage array, contents undefined until written
   data_t mem_q [DEPTH];

   // registered read data
   data_t r_data_q;

   // write port
   always_ff @(posedge clk_i)
   begin
      if (mem.w_v)
         mem_q[mem.w_addr] <= mem.w_data;
   end

   // read port, data held while r_v is low
   // the controller never reads the address being written
   always_ff @(posedge clk_i)
   begin
      if (mem.r_v)
         r_data_q <= mem_q[mem.r_addr];
   end

   assign mem.r_data = r_data_q;

endmodule

/* src/out_reg_stage.sv */
//**************************************
// output register stage: valid/yumi in,
// registered valid/ready out
//**************************************

`timescale 1ns/100ps

module out_reg_stage
   import fifo_geom_pkg::*;
   import stage_ctrl_pkg::*;
(
   input  logic  clk_i,
   input  logic  rst_n_i,
   input  logic  deq_valid_i,
   input  data_t deq_data_i,
   input  logic  out_ready_i,
   output logic  deq_yumi_o,
   output logic  out_valid_o,
   output data_t out_data_o
);

   out_state_e state_q;
   logic       drain;
   data_t      data_q;

   assign out_valid_o = (state_q == OUT_HELD);

   // held word leaves this cycle
   assign drain = out_valid_o & out_ready_i;

   // take a word when the register is free or being emptied now
   assign deq_yumi_o = deq_valid_i & ((state_q == OUT_EMPTY) | out_ready_i);

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         state_q <= OUT_EMPTY;
      else if (deq_yumi_o)
         state_q <= OUT_HELD;
      else if (drain)
         state_q <= OUT_EMPTY;
   end

   // payload only changes on a yumi, so it stays put while stalled
   always_ff @(posedge clk_i)
   begin
      if (deq_yumi_o)
         data_q <= deq_data_i;
   end

   assign out_data_o = data_q;

endmodule

/* src/stage_ctrl_pkg.sv */
//**************************************
// output register stage control types
//**************************************

package stage_ctrl_pkg;

   // whether the output register holds a word
   typedef enum logic [0:0]
   {
      OUT_EMPTY = 1'b0,
      OUT_HELD  = 1'b1
   } out_state_e;

endpackage
